// File: Bender.yml
package:
  name: inst_decode

sources:
  - source/decode_pkg.sv
  - source/decode_if.sv
  - source/ctrl_decoder.sv
  - source/imm_gen.sv
  - source/id_stage_reg.sv
  - source/inst_decode_top.sv
  - target: test
    files:
      - bench/tb_inst_decode.sv

// File: bench/tb_inst_decode.sv
`timescale 1ns/1ps

module tb_inst_decode;

    localparam int N_ALU   = 300;
    localparam int N_MEM   = 200;
    localparam int N_FLOW  = 200;
    localparam int N_RAND  = 200;
    localparam int N_MIXED = 200;
    localparam int TOTAL_INST = N_ALU + N_MEM + N_FLOW + N_RAND + 1 + N_MIXED;
    localparam int MAX_CYCLES = 2 * TOTAL_INST + 8 + 100; // gaps at most double the run

    typedef struct packed {
        logic        reg_wen;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [4:0]  alu_op;
        logic [1:0]  alu_src;
        logic        branch;
        logic        jump;
        logic        jalr;
        logic        mem_read;
        logic        mem_write;
        logic [1:0]  mem_size;
        logic        mem_unsigned;
        logic [7:0]  wmask;
        logic [63:0] imm;
        logic        illegal;
        logic        ebreak;
    } bundle_t;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic        inst_valid;
    logic        out_valid;
    logic        reg_wen;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [4:0]  alu_op;
    logic [1:0]  alu_src;
    logic        branch;
    logic        jump;
    logic        jalr;
    logic        mem_read;
    logic        mem_write;
    logic [1:0]  mem_size;
    logic        mem_unsigned;
    logic [7:0]  wmask;
    logic [63:0] imm;
    logic        illegal;
    logic        ebreak;

    integer  seed;
    int      checks;
    int      errors;
    int      sent;
    logic    mon_on;
    logic    last_valid;
    bundle_t exp_b;
    bundle_t exp_q[$];

    inst_decode_top dut (.*);

    always #5 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // expected decode of one word
    function automatic bundle_t model(input logic [31:0] w);
        bundle_t     b;
        logic        bad;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] i_imm;
        logic [63:0] s_imm;
        logic [63:0] b_imm;
        logic [63:0] u_imm;
        logic [63:0] j_imm;
        b     = '0;
        bad   = 1'b0;
        f3    = w[14:12];
        f7    = w[31:25];
        i_imm = $signed(w[31:20]);
        s_imm = $signed({w[31:25], w[11:7]});
        b_imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
        u_imm = $signed({w[31:12], 12'h000});
        j_imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
        case (w[6:0])
            decode_pkg::OPC_OP: begin
                b.reg_wen = 1'b1;
                b.rs1     = w[19:15];
                b.rs2     = w[24:20];
                b.rd      = w[11:7];
                case ({f7, f3})
                    {7'h00, 3'd0}: b.alu_op = decode_pkg::ADD;
                    {7'h20, 3'd0}: b.alu_op = decode_pkg::SUB;
                    {7'h01, 3'd0}: b.alu_op = decode_pkg::MUL;
                    {7'h00, 3'd7}: b.alu_op = decode_pkg::AND;
                    {7'h00, 3'd6}: b.alu_op = decode_pkg::OR;
                    {7'h00, 3'd2}: b.alu_op = decode_pkg::SLT;
                    {7'h00, 3'd3}: b.alu_op = decode_pkg::SLTU;
                    {7'h01, 3'd5}: b.alu_op = decode_pkg::DIVU;
                    {7'h01, 3'd7}: b.alu_op = decode_pkg::REMU;
                    default:       bad = 1'b1;
                endcase
            end
            decode_pkg::OPC_OP_IMM: begin
                b.reg_wen = 1'b1;
                b.rs1     = w[19:15];
                b.rd      = w[11:7];
                b.alu_src = decode_pkg::SRC_IMM;
                b.imm     = i_imm;
                case (f3)
                    3'd0: b.alu_op = decode_pkg::ADD;
                    3'd3: b.alu_op = decode_pkg::SLTU;
                    3'd7: b.alu_op = decode_pkg::AND;
                    3'd6: b.alu_op = decode_pkg::OR;
                    3'd4: b.alu_op = decode_pkg::XOR;
                    3'd1: b.alu_op = decode_pkg::SLL;
                    3'd5: b.alu_op = w[30] ? decode_pkg::SRA : decode_pkg::SRL;
                    default: bad = 1'b1;
                endcase
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    b.imm = {58'b0, w[25:20]}; // shamt
                    bad   = bad || ({w[31], w[29:26]} != 5'b0) || (f3 == 3'd1 && w[30]);
                end
            end
            decode_pkg::OPC_LOAD: begin
                b.reg_wen  = 1'b1;
                b.rs1      = w[19:15];
                b.rd       = w[11:7];
                b.alu_src  = decode_pkg::SRC_IMM;
                b.mem_read = 1'b1;
                b.imm      = i_imm;
                case (f3)
                    3'd1: b.mem_size = decode_pkg::HALF;
                    3'd2: b.mem_size = decode_pkg::WORD;
                    3'd3: b.mem_size = decode_pkg::DOUBLE;
                    3'd4: b.mem_unsigned = 1'b1; // lbu
                    3'd5: begin
                        b.mem_size     = decode_pkg::HALF;
                        b.mem_unsigned = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            decode_pkg::OPC_STORE: begin
                b.rs1       = w[19:15];
                b.rs2       = w[24:20];
                b.alu_src   = decode_pkg::SRC_IMM;
                b.mem_write = 1'b1;
                b.imm       = s_imm;
                b.mem_size  = f3[1:0];
                case (f3)
                    3'd0: b.wmask = 8'h01;
                    3'd1: b.wmask = 8'h03;
                    3'd2: b.wmask = 8'h0F;
                    3'd3: b.wmask = 8'hFF;
                    default: bad = 1'b1;
                endcase
            end
            decode_pkg::OPC_BRANCH: begin
                b.rs1    = w[19:15];
                b.rs2    = w[24:20];
                b.branch = 1'b1;
                b.imm    = b_imm;
                case (f3)
                    3'd0: b.alu_op = decode_pkg::EQ;
                    3'd1: b.alu_op = decode_pkg::NE;
                    3'd4: b.alu_op = decode_pkg::LT;
                    3'd5: b.alu_op = decode_pkg::GE;
                    3'd6: b.alu_op = decode_pkg::LTU;
                    3'd7: b.alu_op = decode_pkg::GEU;
                    default: bad = 1'b1;
                endcase
            end
            decode_pkg::OPC_JAL: begin
                b.reg_wen = 1'b1;
                b.rd      = w[11:7];
                b.jump    = 1'b1;
                b.alu_src = decode_pkg::SRC_PC_FOUR;
                b.imm     = j_imm;
            end
            decode_pkg::OPC_JALR: begin
                b.reg_wen = 1'b1;
                b.rs1     = w[19:15];
                b.rd      = w[11:7];
                b.jump    = 1'b1;
                b.jalr    = 1'b1;
                b.alu_src = decode_pkg::SRC_PC_FOUR;
                b.imm     = i_imm;
                bad       = (f3 != 3'd0);
            end
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                b.reg_wen = 1'b1;
                b.rd      = w[11:7];
                b.alu_src = (w[5]) ? decode_pkg::SRC_IMM : decode_pkg::SRC_PC_IMM;
                b.imm     = u_imm;
            end
            decode_pkg::OPC_SYSTEM: begin
                b.ebreak = (w == decode_pkg::EBREAK_WORD);
                bad      = !b.ebreak;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            b         = '0;
            b.illegal = 1'b1;
        end
        return b;
    endfunction

    // kind 0 alu, 1 load/store, 2 control flow, 3 random word, 4 any of these
    task automatic make_word(input int kind, output logic [31:0] w);
        logic [31:0] sel;
        int          k;
        w   = $random(seed);
        sel = $random(seed);
        k   = (kind == 4) ? int'(sel[31:30]) : kind;
        case (k)
            0: begin
                if (sel[4]) begin
                    w[6:0] = decode_pkg::OPC_OP;
                    case (sel[3:0] % 9)
                        0: {w[31:25], w[14:12]} = {7'h00, 3'd0};
                        1: {w[31:25], w[14:12]} = {7'h20, 3'd0};
                        2: {w[31:25], w[14:12]} = {7'h00, 3'd7};
                        3: {w[31:25], w[14:12]} = {7'h00, 3'd6};
                        4: {w[31:25], w[14:12]} = {7'h00, 3'd2};
                        5: {w[31:25], w[14:12]} = {7'h00, 3'd3};
                        6: {w[31:25], w[14:12]} = {7'h01, 3'd0};
                        7: {w[31:25], w[14:12]} = {7'h01, 3'd5};
                        default: {w[31:25], w[14:12]} = {7'h01, 3'd7};
                    endcase
                end else begin
                    w[6:0] = decode_pkg::OPC_OP_IMM;
                    case (sel[2:0])
                        0: w[14:12] = 3'd0;
                        1: w[14:12] = 3'd3;
                        2: w[14:12] = 3'd7;
                        3: w[14:12] = 3'd6;
                        4: w[14:12] = 3'd4;
                        5: {w[31:26], w[14:12]} = {6'h00, 3'd1};
                        6: {w[31:26], w[14:12]} = {6'h00, 3'd5};
                        default: {w[31:26], w[14:12]} = {6'h10, 3'd5};
                    endcase
                end
            end
            1: begin
                if (sel[3]) begin
                    w[6:0]   = decode_pkg::OPC_LOAD;
                    w[14:12] = 3'd1 + 3'(sel[2:0] % 5); // lh .. lhu
                end else begin
                    w[6:0]   = decode_pkg::OPC_STORE;
                    w[14:12] = {1'b0, sel[1:0]};
                end
            end
            2: begin
                case (sel[3:0] % 10)
                    0, 1, 2, 3, 4, 5: begin
                        w[6:0] = decode_pkg::OPC_BRANCH;
                        w[14:12] = (sel[2:0] < 3'd2) ? sel[2:0] : {1'b1, sel[5:4]};
                    end
                    6: w[6:0] = decode_pkg::OPC_JAL;
                    7: begin
                        w[6:0]   = decode_pkg::OPC_JALR;
                        w[14:12] = 3'd0;
                    end
                    8: w[6:0] = decode_pkg::OPC_LUI;
                    default: w[6:0] = decode_pkg::OPC_AUIPC;
                endcase
            end
            default: ;
        endcase
    endtask

    task automatic drive_word(input logic [31:0] w);
        @(posedge clk);
        #1;
        inst       = w;
        inst_valid = 1'b1;
        exp_q.push_back(model(w));
        sent++;
    endtask

    task automatic run_test(input string name, input int kind, input int count,
                            input logic with_gaps, input logic add_ebreak);
        logic [31:0] w;
        int          err_start;
        err_start = errors;
        if (add_ebreak) begin
            drive_word(decode_pkg::EBREAK_WORD);
        end
        for (int i = 0; i < count; i++) begin
            while (with_gaps && ($random(seed) & 3) == 0) begin
                @(posedge clk);
                #1;
                inst_valid = 1'b0;
                inst       = $random(seed); // junk while idle
            end
            make_word(kind, w);
            drive_word(w);
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        wait (exp_q.size() == 0);
        @(negedge clk);
        $display("test %s: %0d instructions, %0d errors", name,
                 count + int'(add_ebreak), errors - err_start);
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (mon_on) begin
            check("out_valid", out_valid, last_valid);
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("out_valid went high with no instruction pending at %0t", $time);
                end else begin
                    exp_b = exp_q.pop_front();
                    check("reg_wen", reg_wen, exp_b.reg_wen);
                    check("rs1", rs1, exp_b.rs1);
                    check("rs2", rs2, exp_b.rs2);
                    check("rd", rd, exp_b.rd);
                    check("alu_op", alu_op, exp_b.alu_op);
                    check("alu_src", alu_src, exp_b.alu_src);
                    check("branch", branch, exp_b.branch);
                    check("jump", jump, exp_b.jump);
                    check("jalr", jalr, exp_b.jalr);
                    check("mem_read", mem_read, exp_b.mem_read);
                    check("mem_write", mem_write, exp_b.mem_write);
                    check("mem_size", mem_size, exp_b.mem_size);
                    check("mem_unsigned", mem_unsigned, exp_b.mem_unsigned);
                    check("wmask", wmask, exp_b.wmask);
                    check("imm", imm, exp_b.imm);
                    check("illegal", illegal, exp_b.illegal);
                    check("ebreak", ebreak, exp_b.ebreak);
                end
            end else begin
                check("idle_flags", {reg_wen, branch, jump, jalr, mem_read, mem_write,
                                     illegal, ebreak}, 64'h0);
            end
        end
        last_valid = inst_valid && !rst; // sampled at the coming rising edge
    end

    initial begin
        #(MAX_CYCLES * 10);
        $display("watchdog expired after %0d cycles, decode stage stopped responding",
                 MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int          err_start;
        logic [31:0] w;
        seed       = 8;
        checks     = 0;
        errors     = 0;
        sent       = 0;
        mon_on     = 1'b0;
        last_valid = 1'b0;
        clk        = 1'b0;
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        err_start  = 0;

        @(posedge clk);
        #1;
        mon_on = 1'b1;
        make_word(0, w);
        inst       = w;
        inst_valid = 1'b1; // must be dropped while rst is high
        repeat (7) @(posedge clk);
        #1;
        rst        = 1'b0;
        inst_valid = 1'b0;
        @(posedge clk);
        @(negedge clk);
        $display("test reset: 0 instructions, %0d errors", errors - err_start);

        run_test("alu_decode", 0, N_ALU, 1'b0, 1'b0);
        run_test("load_store", 1, N_MEM, 1'b0, 1'b0);
        run_test("control_flow", 2, N_FLOW, 1'b0, 1'b0);
        run_test("illegal_ebreak", 3, N_RAND, 1'b0, 1'b1);
        run_test("throughput", 4, N_MIXED, 1'b1, 1'b0);

        $display("summary: %0d instructions, %0d checks, %0d errors, %0d pending",
                 sent, checks, errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
source/decode_pkg.sv
source/decode_if.sv
source/ctrl_decoder.sv
source/imm_gen.sv
source/id_stage_reg.sv
source/inst_decode_top.sv
bench/tb_inst_decode.sv

// File: source/ctrl_decoder.sv
`timescale 1ns/1ps

module ctrl_decoder #(
    parameter int INST_W = decode_pkg::INST_W
) (
    input  logic [INST_W-1:0]    inst,
    decode_if.producer           ctl,
    output decode_pkg::imm_kind_e imm_kind
);

    logic [6:0]                        opcode;
    logic [2:0]                        funct3;
    logic [6:0]                        funct7;
    logic [5:0]                        funct6;
    logic [decode_pkg::REG_ADDR_W-1:0] rd;
    logic [decode_pkg::REG_ADDR_W-1:0] rs1;
    logic [decode_pkg::REG_ADDR_W-1:0] rs2;
    logic                              bad;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign funct6 = inst[31:26]; // shamt[5] sits in bit 25
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        bad              = 1'b0;
        ctl.reg_wen      = 1'b0;
        ctl.rs1          = '0;
        ctl.rs2          = '0;
        ctl.rd           = '0;
        ctl.alu_op       = decode_pkg::ADD;
        ctl.alu_src      = decode_pkg::SRC_REG;
        ctl.branch       = 1'b0;
        ctl.jump         = 1'b0;
        ctl.jalr         = 1'b0;
        ctl.mem_read     = 1'b0;
        ctl.mem_write    = 1'b0;
        ctl.mem_size     = decode_pkg::BYTE;
        ctl.mem_unsigned = 1'b0;
        ctl.wmask        = 8'h00;
        ctl.ebreak       = 1'b0;
        imm_kind         = decode_pkg::IMM_NONE;

        case (opcode)
            decode_pkg::OPC_OP: begin
                ctl.reg_wen = 1'b1;
                ctl.rs1     = rs1;
                ctl.rs2     = rs2;
                ctl.rd      = rd;
                case ({funct7, funct3})
                    {decode_pkg::F7_BASE, 3'b000}:   ctl.alu_op = decode_pkg::ADD;
                    {decode_pkg::F7_ALT, 3'b000}:    ctl.alu_op = decode_pkg::SUB;
                    {decode_pkg::F7_MULDIV, 3'b000}: ctl.alu_op = decode_pkg::MUL;
                    {decode_pkg::F7_BASE, 3'b111}:   ctl.alu_op = decode_pkg::AND;
                    {decode_pkg::F7_BASE, 3'b110}:   ctl.alu_op = decode_pkg::OR;
                    {decode_pkg::F7_BASE, 3'b010}:   ctl.alu_op = decode_pkg::SLT;
                    {decode_pkg::F7_BASE, 3'b011}:   ctl.alu_op = decode_pkg::SLTU;
                    {decode_pkg::F7_MULDIV, 3'b101}: ctl.alu_op = decode_pkg::DIVU;
                    {decode_pkg::F7_MULDIV, 3'b111}: ctl.alu_op = decode_pkg::REMU;
                    default:                         bad = 1'b1;
                endcase
            end
            decode_pkg::OPC_OP_IMM: begin
                ctl.reg_wen = 1'b1;
                ctl.rs1     = rs1;
                ctl.rd      = rd;
                ctl.alu_src = decode_pkg::SRC_IMM;
                imm_kind    = decode_pkg::IMM_I;
                case (funct3)
                    3'b000: ctl.alu_op = decode_pkg::ADD;
                    3'b011: ctl.alu_op = decode_pkg::SLTU;
                    3'b111: ctl.alu_op = decode_pkg::AND;
                    3'b110: ctl.alu_op = decode_pkg::OR;
                    3'b100: ctl.alu_op = decode_pkg::XOR;
                    3'b001: begin
                        ctl.alu_op = decode_pkg::SLL;
                        imm_kind   = decode_pkg::IMM_SHAMT;
                        bad        = (funct6 != decode_pkg::F6_SRL);
                    end
                    3'b101: begin
                        imm_kind = decode_pkg::IMM_SHAMT;
                        if (funct6 == decode_pkg::F6_SRL) begin
                            ctl.alu_op = decode_pkg::SRL;
                        end else if (funct6 == decode_pkg::F6_SRA) begin
                            ctl.alu_op = decode_pkg::SRA;
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    default: bad = 1'b1; // slti not kept
                endcase
            end
            decode_pkg::OPC_LOAD: begin
                ctl.reg_wen  = 1'b1;
                ctl.rs1      = rs1;
                ctl.rd       = rd;
                ctl.alu_src  = decode_pkg::SRC_IMM; // address = rs1 + imm
                ctl.mem_read = 1'b1;
                imm_kind     = decode_pkg::IMM_I;
                case (funct3)
                    3'b001: ctl.mem_size = decode_pkg::HALF;
                    3'b010: ctl.mem_size = decode_pkg::WORD;
                    3'b011: ctl.mem_size = decode_pkg::DOUBLE;
                    3'b100: begin
                        ctl.mem_size     = decode_pkg::BYTE;
                        ctl.mem_unsigned = 1'b1;
                    end
                    3'b101: begin
                        ctl.mem_size     = decode_pkg::HALF;
                        ctl.mem_unsigned = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end
            decode_pkg::OPC_STORE: begin
                ctl.rs1       = rs1;
                ctl.rs2       = rs2;
                ctl.alu_src   = decode_pkg::SRC_IMM;
                ctl.mem_write = 1'b1;
                imm_kind      = decode_pkg::IMM_S;
                case (funct3)
                    3'b000: ctl.wmask = 8'h01;
                    3'b001: ctl.wmask = 8'h03;
                    3'b010: ctl.wmask = 8'h0F;
                    3'b011: ctl.wmask = 8'hFF;
                    default: bad = 1'b1;
                endcase
                ctl.mem_size = decode_pkg::mem_size_e'(funct3[1:0]);
            end
            decode_pkg::OPC_BRANCH: begin
                ctl.rs1    = rs1;
                ctl.rs2    = rs2;
                ctl.branch = 1'b1;
                imm_kind   = decode_pkg::IMM_B;
                case (funct3)
                    3'b000: ctl.alu_op = decode_pkg::EQ;
                    3'b001: ctl.alu_op = decode_pkg::NE;
                    3'b100: ctl.alu_op = decode_pkg::LT;
                    3'b101: ctl.alu_op = decode_pkg::GE;
                    3'b110: ctl.alu_op = decode_pkg::LTU;
                    3'b111: ctl.alu_op = decode_pkg::GEU;
                    default: bad = 1'b1;
                endcase
            end
            decode_pkg::OPC_JAL: begin
                ctl.reg_wen = 1'b1;
                ctl.rd      = rd;
                ctl.jump    = 1'b1;
                ctl.alu_src = decode_pkg::SRC_PC_FOUR; // link value
                imm_kind    = decode_pkg::IMM_J;
            end
            decode_pkg::OPC_JALR: begin
                ctl.reg_wen = 1'b1;
                ctl.rs1     = rs1;
                ctl.rd      = rd;
                ctl.jump    = 1'b1;
                ctl.jalr    = 1'b1;
                ctl.alu_src = decode_pkg::SRC_PC_FOUR;
                imm_kind    = decode_pkg::IMM_I;
                bad         = (funct3 != 3'b000);
            end
            decode_pkg::OPC_LUI: begin
                ctl.reg_wen = 1'b1;
                ctl.rd      = rd;
                ctl.alu_src = decode_pkg::SRC_IMM; // x0 + imm
                imm_kind    = decode_pkg::IMM_U;
            end
            decode_pkg::OPC_AUIPC: begin
                ctl.reg_wen = 1'b1;
                ctl.rd      = rd;
                ctl.alu_src = decode_pkg::SRC_PC_IMM;
                imm_kind    = decode_pkg::IMM_U;
            end
            decode_pkg::OPC_SYSTEM: begin
                if (inst == decode_pkg::EBREAK_WORD) begin
                    ctl.ebreak = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = 1'b1;
        endcase

        // an unknown word must not disturb the rest of the pipe
        if (bad) begin
            ctl.reg_wen      = 1'b0;
            ctl.rs1          = '0;
            ctl.rs2          = '0;
            ctl.rd           = '0;
            ctl.alu_op       = decode_pkg::ADD;
            ctl.alu_src      = decode_pkg::SRC_REG;
            ctl.branch       = 1'b0;
            ctl.jump         = 1'b0;
            ctl.jalr         = 1'b0;
            ctl.mem_read     = 1'b0;
            ctl.mem_write    = 1'b0;
            ctl.mem_size     = decode_pkg::BYTE;
            ctl.mem_unsigned = 1'b0;
            ctl.wmask        = 8'h00;
            imm_kind         = decode_pkg::IMM_NONE;
        end
        ctl.illegal = bad;
    end

    illegal_no_wen: assert final (!(ctl.illegal && ctl.reg_wen))
        else $error("illegal word with reg_wen set, inst %h", inst);

endmodule

// File: source/decode_if.sv
`timescale 1ns/1ps

interface decode_if #(
    parameter int XLEN = decode_pkg::XLEN
);
    logic                               reg_wen;
    logic [decode_pkg::REG_ADDR_W-1:0]  rs1;
    logic [decode_pkg::REG_ADDR_W-1:0]  rs2;
    logic [decode_pkg::REG_ADDR_W-1:0]  rd;
    decode_pkg::alu_op_e                alu_op;
    decode_pkg::alu_src_e               alu_src;
    logic                               branch;
    logic                               jump;
    logic                               jalr;
    logic                               mem_read;
    logic                               mem_write;
    decode_pkg::mem_size_e              mem_size;
    logic                               mem_unsigned;
    logic [7:0]                         wmask;   // byte lanes
    logic [XLEN-1:0]                    imm;
    logic                               illegal;
    logic                               ebreak;

    modport producer (
        output reg_wen, rs1, rs2, rd, alu_op, alu_src, branch, jump, jalr,
               mem_read, mem_write, mem_size, mem_unsigned, wmask, imm, illegal, ebreak
    );

    modport consumer (
        input  reg_wen, rs1, rs2, rd, alu_op, alu_src, branch, jump, jalr,
               mem_read, mem_write, mem_size, mem_unsigned, wmask, imm, illegal, ebreak
    );

endinterface

// File: source/decode_pkg.sv
package decode_pkg;

    localparam int XLEN       = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub
    localparam logic [6:0] F7_MULDIV = 7'b0000001; // M extension

    // 64-bit shifts use a 6-bit shamt
    localparam logic [5:0] F6_SRL = 6'b000000;
    localparam logic [5:0] F6_SRA = 6'b010000;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        MUL,
        DIVU,
        REMU,
        EQ,    // branch compares
        NE,
        LT,
        GE,
        LTU,
        GEU
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_PC_FOUR, // pc + 4
        SRC_PC_IMM   // pc + imm
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT
    } imm_kind_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD,
        DOUBLE
    } mem_size_e;

endpackage

// File: source/id_stage_reg.sv
`timescale 1ns/1ps

module id_stage_reg #(
    parameter int XLEN = decode_pkg::XLEN
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_valid,
    decode_if.consumer                        ctl_in,
    output logic                              out_valid,
    output logic                              reg_wen,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd,
    output decode_pkg::alu_op_e               alu_op,
    output decode_pkg::alu_src_e              alu_src,
    output logic                              branch,
    output logic                              jump,
    output logic                              jalr,
    output logic                              mem_read,
    output logic                              mem_write,
    output decode_pkg::mem_size_e             mem_size,
    output logic                              mem_unsigned,
    output logic [7:0]                        wmask,
    output logic [XLEN-1:0]                   imm,
    output logic                              illegal,
    output logic                              ebreak
);

    // enables and flags, zeroed on a bubble
    always_ff @(posedge clk) begin
        if (rst || !in_valid) begin
            out_valid <= 1'b0;
            reg_wen   <= 1'b0;
            branch    <= 1'b0;
            jump      <= 1'b0;
            jalr      <= 1'b0;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            wmask     <= 8'h00;
            illegal   <= 1'b0;
            ebreak    <= 1'b0;
        end else begin
            out_valid <= 1'b1;
            reg_wen   <= ctl_in.reg_wen;
            branch    <= ctl_in.branch;
            jump      <= ctl_in.jump;
            jalr      <= ctl_in.jalr;
            mem_read  <= ctl_in.mem_read;
            mem_write <= ctl_in.mem_write;
            wmask     <= ctl_in.wmask;
            illegal   <= ctl_in.illegal;
            ebreak    <= ctl_in.ebreak;
        end
    end

    always_ff @(posedge clk) begin
        rs1          <= ctl_in.rs1;
        rs2          <= ctl_in.rs2;
        rd           <= ctl_in.rd;
        alu_op       <= ctl_in.alu_op;
        alu_src      <= ctl_in.alu_src;
        mem_size     <= ctl_in.mem_size;
        mem_unsigned <= ctl_in.mem_unsigned;
        imm          <= ctl_in.imm;
    end

    mem_excl: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !(mem_read && mem_write))
        else $error("load and store issued together");

    flow_excl: assert property (@(posedge clk) disable iff (rst) !(branch && jump))
        else $error("branch and jump both set");

endmodule

// File: source/imm_gen.sv
`timescale 1ns/1ps

module imm_gen #(
    parameter int XLEN   = decode_pkg::XLEN,
    parameter int INST_W = decode_pkg::INST_W
) (
    input  logic [INST_W-1:0]     inst,
    input  decode_pkg::imm_kind_e imm_kind,
    output logic [XLEN-1:0]       imm
);

    logic sign;

    assign sign = inst[INST_W-1];

    always_comb begin
        case (imm_kind)
            decode_pkg::IMM_I: begin
                imm = {{(XLEN-12){sign}}, inst[31:20]};
            end
            decode_pkg::IMM_S: begin
                imm = {{(XLEN-12){sign}}, inst[31:25], inst[11:7]};
            end
            decode_pkg::IMM_B: begin
                imm = {{(XLEN-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            decode_pkg::IMM_U: begin
                imm = {{(XLEN-32){sign}}, inst[31:12], 12'h000}; // upper 20 bits
            end
            decode_pkg::IMM_J: begin
                imm = {{(XLEN-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            decode_pkg::IMM_SHAMT: begin
                imm = {{(XLEN-6){1'b0}}, inst[25:20]}; // 6-bit shamt, no sign
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: source/inst_decode_top.sv
`timescale 1ns/1ps

module inst_decode_top #(
    parameter int XLEN   = decode_pkg::XLEN,
    parameter int INST_W = decode_pkg::INST_W
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [INST_W-1:0]                 inst,
    input  logic                              inst_valid,
    output logic                              out_valid,
    output logic                              reg_wen,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd,
    output decode_pkg::alu_op_e               alu_op,
    output decode_pkg::alu_src_e              alu_src,
    output logic                              branch,
    output logic                              jump,
    output logic                              jalr,
    output logic                              mem_read,
    output logic                              mem_write,
    output decode_pkg::mem_size_e             mem_size,
    output logic                              mem_unsigned,
    output logic [7:0]                        wmask,
    output logic [XLEN-1:0]                   imm,
    output logic                              illegal,
    output logic                              ebreak
);

    decode_pkg::imm_kind_e imm_kind;
    logic [XLEN-1:0]       imm_comb; // unregistered immediate

    decode_if #(.XLEN(XLEN)) ctl_bus ();

    ctrl_decoder #(
        .INST_W   (INST_W)
    ) u_ctrl (
        .inst     (inst),
        .ctl      (ctl_bus.producer),
        .imm_kind (imm_kind)
    );

    imm_gen #(
        .XLEN     (XLEN),
        .INST_W   (INST_W)
    ) u_imm (
        .inst     (inst),
        .imm_kind (imm_kind),
        .imm      (imm_comb)
    );

    assign ctl_bus.imm = imm_comb;

    id_stage_reg #(
        .XLEN     (XLEN)
    ) u_stage (
        .*,
        .in_valid (inst_valid),
        .ctl_in   (ctl_bus.consumer)
    );

endmodule
